/* hw/fence_inst_pkg.sv */
// Fence instruction encodings
// Opcode, funct3 and funct7 values of the special instructions handled
// by the CP0 fence sequencer, plus register field positions
package fence_inst_pkg;

  // ==========================================================================
  // Major opcodes
  // ==========================================================================
  // fence and fence.i
  localparam logic [6:0] opc_misc_mem = 7'b0001111;
  // sfence.vma
  localparam logic [6:0] opc_system   = 7'b1110011;
  // Vendor sync and sync.i
  localparam logic [6:0] opc_custom0  = 7'b0001011;

  // ==========================================================================
  // Minor fields
  // ==========================================================================
  // MISC-MEM funct3
  localparam logic [2:0] f3_fence  = 3'b000;
  localparam logic [2:0] f3_fencei = 3'b001;

  // sfence.vma funct7, funct3 is zero
  localparam logic [6:0] f7_sfence_vma = 7'b0001001;

  // ==========================================================================
  // Full custom words
  // ==========================================================================
  // No operands, matched as whole words
  localparam logic [31:0] sync_word  = 32'h0180000b;
  localparam logic [31:0] synci_word = 32'h01a0000b;

  // ==========================================================================
  // Field positions
  // ==========================================================================
  // Low bit of each 5-bit register field
  localparam int unsigned rd_lsb  = 7;
  localparam int unsigned rs1_lsb = 15;
  localparam int unsigned rs2_lsb = 20;

  // Upper fields
  localparam int unsigned f3_lsb = 12;
  localparam int unsigned f7_lsb = 25;

endpackage

/* hw/fence_ctrl_pkg.sv */
// Fence sequencer control types
// State encoding of the fence FSM and the packed structs that carry the
// held command, the outgoing request levels and the retire result
package fence_ctrl_pkg;

  // State register width
  localparam int unsigned state_w = 3;

  // ==========================================================================
  // FSM states
  // ==========================================================================
  typedef enum logic [state_w-1:0] {
    // Waiting for a command
    fnc_idle  = 3'b000,
    // LSU drain for sync and sync.i
    fnc_fenc  = 3'b001,
    // D-cache clean
    fnc_cdca  = 3'b010,
    // TLB clean
    fnc_cmmu  = 3'b011,
    // I-cache invalidate
    fnc_iica  = 3'b100,
    // One-cycle completion
    fnc_cmplt = 3'b101
  } fence_state_e;

  // ==========================================================================
  // Held command
  // ==========================================================================
  // Valid plus nine payload bits
  typedef struct packed {
    logic vld;
    logic fence;
    logic fencei;
    logic sfence;
    logic sync;
    logic synci;
    logic dcacheop;
    logic icacheop;
    // Register operands are x0
    logic rs1_x0;
    logic rs2_x0;
  } fence_cmd_t;

  // ==========================================================================
  // Request levels
  // ==========================================================================
  // Each held until its matching ack or done pulse
  typedef struct packed {
    logic lsu_fence;
    logic lsu_sync;
    logic dcache;
    logic icache;
    logic mmu;
  } fence_req_t;

  // ==========================================================================
  // Retire result
  // ==========================================================================
  typedef struct packed {
    // One-cycle retire pulse
    logic done;
    // TLB clear kinds, levels during TLB clean
    logic clr_va_all;
    logic clr_asid_all;
    logic clr_va_asid;
  } fence_retire_t;

endpackage

/* hw/fence_special_decode.sv */
// Fence special-instruction decode
// Classifies the issued word, samples the CSR cache-op levels when free
// and holds one command until the result block retires it
`timescale 1ns/1ps

module fence_special_decode (
  input  logic                     fence_clk,
  input  logic                     cpurst_b,
  input  logic                     inst_issue,
  input  logic [31:0]              inst_word,
  input  logic                     dcacheop_req,
  input  logic                     icacheop_req,
  input  logic                     retire_done,
  output fence_ctrl_pkg::fence_cmd_t cmd
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd_f;
  logic [4:0] rs1_f;
  logic [4:0] rs2_f;

  // Kind matches
  logic hit_fence;
  logic hit_fencei;
  logic hit_sfence;
  logic hit_sync;
  logic hit_synci;
  logic hit_special;

  fence_ctrl_pkg::fence_cmd_t inst_cmd;
  fence_ctrl_pkg::fence_cmd_t csr_cmd;
  fence_ctrl_pkg::fence_cmd_t cmd_q;

  assign opcode = inst_word[6:0];
  assign funct3 = inst_word[fence_inst_pkg::f3_lsb +: 3];
  assign funct7 = inst_word[fence_inst_pkg::f7_lsb +: 7];
  assign rd_f   = inst_word[fence_inst_pkg::rd_lsb +: 5];
  assign rs1_f  = inst_word[fence_inst_pkg::rs1_lsb +: 5];
  assign rs2_f  = inst_word[fence_inst_pkg::rs2_lsb +: 5];

  // ==========================================================================
  // Classification
  // ==========================================================================
  assign hit_fence  = (opcode == fence_inst_pkg::opc_misc_mem)
                   && (funct3 == fence_inst_pkg::f3_fence);
  assign hit_fencei = (opcode == fence_inst_pkg::opc_misc_mem)
                   && (funct3 == fence_inst_pkg::f3_fencei);
  // sfence.vma, rd and funct3 must be zero
  assign hit_sfence = (opcode == fence_inst_pkg::opc_system)
                   && (funct3 == 3'b000)
                   && (funct7 == fence_inst_pkg::f7_sfence_vma)
                   && (rd_f == 5'd0);
  // Vendor words, whole-word compare
  assign hit_sync   = (opcode == fence_inst_pkg::opc_custom0)
                   && (inst_word == fence_inst_pkg::sync_word);
  assign hit_synci  = (opcode == fence_inst_pkg::opc_custom0)
                   && (inst_word == fence_inst_pkg::synci_word);

  assign hit_special = hit_fence | hit_fencei | hit_sfence | hit_sync | hit_synci;

  // Command built from the issued word
  always_comb
  begin
    inst_cmd        = '0;
    inst_cmd.vld    = hit_special;
    inst_cmd.fence  = hit_fence;
    inst_cmd.fencei = hit_fencei;
    inst_cmd.sfence = hit_sfence;
    inst_cmd.sync   = hit_sync;
    inst_cmd.synci  = hit_synci;
    inst_cmd.rs1_x0 = (rs1_f == 5'd0);
    inst_cmd.rs2_x0 = (rs2_f == 5'd0);
  end

  // CSR cache op, icache wins as in the FSM
  always_comb
  begin
    csr_cmd          = '0;
    csr_cmd.vld      = icacheop_req | dcacheop_req;
    csr_cmd.icacheop = icacheop_req;
    csr_cmd.dcacheop = dcacheop_req & ~icacheop_req;
  end

  // ==========================================================================
  // Command hold
  // ==========================================================================
  // Issue ignored while busy, issued word beats CSR levels
  always_ff @(posedge fence_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cmd_q <= '0;
    else if (retire_done)
      cmd_q <= '0;
    else if (!cmd_q.vld)
    begin
      if (inst_issue && hit_special)
        cmd_q <= inst_cmd;
      else if (!inst_issue)
        cmd_q <= csr_cmd;
    end
  end

  assign cmd = cmd_q;

  // Only one kind held at a time
  a_cmd_onehot: assert property (@(posedge fence_clk) disable iff (!cpurst_b)
    cmd_q.vld |-> $onehot({cmd_q.fence, cmd_q.fencei, cmd_q.sfence, cmd_q.sync,
                           cmd_q.synci, cmd_q.dcacheop, cmd_q.icacheop}));

endmodule

/* hw/fence_seq_ctrl.sv */
// Fence sequencer FSM
// Walks the maintenance sequence of the held command and drives request
// levels to the LSU, D-cache, I-cache and MMU, one done pulse per state
`timescale 1ns/1ps

module fence_seq_ctrl (
  input  logic                         fence_clk,
  input  logic                         cpurst_b,
  input  fence_ctrl_pkg::fence_cmd_t   cmd,
  input  logic                         lsu_fence_ack,
  input  logic                         lsu_sync_ack,
  input  logic                         dcache_done,
  input  logic                         icache_done,
  input  logic                         mmu_done,
  output fence_ctrl_pkg::fence_state_e state,
  output fence_ctrl_pkg::fence_req_t   req
);

  fence_ctrl_pkg::fence_state_e cur_state;
  fence_ctrl_pkg::fence_state_e next_state;

  // Commands that walk the FSM, plain fence stays in idle
  logic seq_cmd_vld;

  assign seq_cmd_vld = cmd.vld & ~cmd.fence;

  // ==========================================================================
  // State register
  // ==========================================================================
  always_ff @(posedge fence_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= fence_ctrl_pkg::fnc_idle;
    else
      cur_state <= next_state;
  end

  // ==========================================================================
  // Next state
  // ==========================================================================
  always_comb
  begin
    next_state = cur_state;
    case (cur_state)
      fence_ctrl_pkg::fnc_idle:
      begin
        // First work state per kind
        if (seq_cmd_vld)
        begin
          if (cmd.icacheop)
            next_state = fence_ctrl_pkg::fnc_iica;
          else if (cmd.dcacheop || cmd.fencei)
            next_state = fence_ctrl_pkg::fnc_cdca;
          else if (cmd.sfence)
            next_state = fence_ctrl_pkg::fnc_cmmu;
          else
            next_state = fence_ctrl_pkg::fnc_fenc;
        end
      end
      fence_ctrl_pkg::fnc_fenc:
      begin
        // sync and sync.i drain
        if (lsu_sync_ack)
          next_state = fence_ctrl_pkg::fnc_cmplt;
      end
      fence_ctrl_pkg::fnc_cdca:
      begin
        // CSR dcache op ends here, fence.i goes on to icache
        if (dcache_done)
        begin
          if (cmd.dcacheop)
            next_state = fence_ctrl_pkg::fnc_cmplt;
          else
            next_state = fence_ctrl_pkg::fnc_iica;
        end
      end
      fence_ctrl_pkg::fnc_cmmu:
      begin
        if (mmu_done)
          next_state = fence_ctrl_pkg::fnc_iica;
      end
      fence_ctrl_pkg::fnc_iica:
      begin
        if (icache_done)
          next_state = fence_ctrl_pkg::fnc_cmplt;
      end
      fence_ctrl_pkg::fnc_cmplt:
      begin
        // Single cycle, command clears on same edge
        next_state = fence_ctrl_pkg::fnc_idle;
      end
      default:
      begin
        next_state = fence_ctrl_pkg::fnc_idle;
      end
    endcase
  end

  // ==========================================================================
  // Requests
  // ==========================================================================
  always_comb
  begin
    req           = '0;
    // Plain fence, level while held
    req.lsu_fence = cmd.vld & cmd.fence;
    req.lsu_sync  = (cur_state == fence_ctrl_pkg::fnc_fenc);
    req.dcache    = (cur_state == fence_ctrl_pkg::fnc_cdca);
    req.icache    = (cur_state == fence_ctrl_pkg::fnc_iica);
    req.mmu       = (cur_state == fence_ctrl_pkg::fnc_cmmu);
  end

  assign state = cur_state;

  // ==========================================================================
  // Checks
  // ==========================================================================
  a_state_legal: assert property (@(posedge fence_clk) disable iff (!cpurst_b)
    cur_state inside {fence_ctrl_pkg::fnc_idle, fence_ctrl_pkg::fnc_fenc,
                      fence_ctrl_pkg::fnc_cdca, fence_ctrl_pkg::fnc_cmmu,
                      fence_ctrl_pkg::fnc_iica, fence_ctrl_pkg::fnc_cmplt});

  a_cache_excl: assert property (@(posedge fence_clk) disable iff (!cpurst_b)
    !(req.dcache && req.icache));

  // Fence ack only answers a plain fence, which never leaves idle
  a_fence_ack_idle: assert property (@(posedge fence_clk) disable iff (!cpurst_b)
    lsu_fence_ack |-> req.lsu_fence && (cur_state == fence_ctrl_pkg::fnc_idle));

endmodule

/* hw/fence_retire.sv */
// Fence result stage
// Forms the retire pulse, the pipeline stall and the TLB clear kinds
// shown to the MMU while the sequencer sits in TLB clean
`timescale 1ns/1ps

module fence_retire (
  input  logic                         fence_clk,
  input  logic                         cpurst_b,
  input  fence_ctrl_pkg::fence_cmd_t   cmd,
  input  fence_ctrl_pkg::fence_state_e state,
  input  logic                         lsu_fence_ack,
  output fence_ctrl_pkg::fence_retire_t retire,
  output logic                         fence_stall
);

  logic in_cmplt;
  logic in_cmmu;
  // Completion seen last cycle
  logic cmplt_seen_q;
  logic fence_done;
  logic seq_done;

  assign in_cmplt = (state == fence_ctrl_pkg::fnc_cmplt);
  assign in_cmmu  = (state == fence_ctrl_pkg::fnc_cmmu);

  // ==========================================================================
  // Retire pulse
  // ==========================================================================
  always_ff @(posedge fence_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cmplt_seen_q <= 1'b0;
    else
      cmplt_seen_q <= in_cmplt;
  end

  // FSM path, first cmplt cycle only
  assign seq_done   = in_cmplt & ~cmplt_seen_q;
  // Plain fence retires on the ack
  assign fence_done = cmd.vld & cmd.fence & lsu_fence_ack;

  // ==========================================================================
  // SFENCE clear kinds
  // ==========================================================================
  // All low means flush the whole TLB
  always_comb
  begin
    retire              = '0;
    retire.done         = seq_done | fence_done;
    retire.clr_va_all   = in_cmmu & cmd.sfence & ~cmd.rs1_x0 &  cmd.rs2_x0;
    retire.clr_asid_all = in_cmmu & cmd.sfence &  cmd.rs1_x0 & ~cmd.rs2_x0;
    retire.clr_va_asid  = in_cmmu & cmd.sfence & ~cmd.rs1_x0 & ~cmd.rs2_x0;
  end

  // Stall from capture through the retire cycle
  assign fence_stall = cmd.vld | (state != fence_ctrl_pkg::fnc_idle);

  // ==========================================================================
  // Checks
  // ==========================================================================
  // cmplt never repeats for one command
  a_cmplt_once: assert property (@(posedge fence_clk) disable iff (!cpurst_b)
    cmplt_seen_q |-> !in_cmplt);

  // Decode drops the command right after retire
  a_cmd_release: assert property (@(posedge fence_clk) disable iff (!cpurst_b)
    retire.done |=> !cmd.vld);

endmodule

/* hw/fence_unit_top.sv */
// Fence unit top level
// Decode, FSM sequencer and result stage of the CP0 fence and
// cache-maintenance path
`timescale 1ns/1ps

module fence_unit_top (
  input  logic                          fence_clk,
  input  logic                          cpurst_b,
  // Issue side
  input  logic                          inst_issue,
  input  logic [31:0]                   inst_word,
  // CSR cache-op levels
  input  logic                          dcacheop_req,
  input  logic                          icacheop_req,
  // Responder pulses
  input  logic                          lsu_fence_ack,
  input  logic                          lsu_sync_ack,
  input  logic                          dcache_done,
  input  logic                          icache_done,
  input  logic                          mmu_done,
  // Results
  output fence_ctrl_pkg::fence_req_t    req,
  output fence_ctrl_pkg::fence_retire_t retire,
  output logic                          fence_stall,
  output fence_ctrl_pkg::fence_state_e  cur_state
);

  fence_ctrl_pkg::fence_cmd_t   cmd;
  fence_ctrl_pkg::fence_state_e state;

  // ==========================================================================
  // Decode
  // ==========================================================================
  fence_special_decode u_decode (
    .fence_clk    (fence_clk),
    .cpurst_b     (cpurst_b),
    .inst_issue   (inst_issue),
    .inst_word    (inst_word),
    .dcacheop_req (dcacheop_req),
    .icacheop_req (icacheop_req),
    .retire_done  (retire.done),
    .cmd          (cmd)
  );

  // ==========================================================================
  // Execute
  // ==========================================================================
  fence_seq_ctrl u_exec (
    .fence_clk     (fence_clk),
    .cpurst_b      (cpurst_b),
    .cmd           (cmd),
    .lsu_fence_ack (lsu_fence_ack),
    .lsu_sync_ack  (lsu_sync_ack),
    .dcache_done   (dcache_done),
    .icache_done   (icache_done),
    .mmu_done      (mmu_done),
    .state         (state),
    .req           (req)
  );

  // ==========================================================================
  // Result
  // ==========================================================================
  fence_retire u_result (
    .fence_clk     (fence_clk),
    .cpurst_b      (cpurst_b),
    .cmd           (cmd),
    .state         (state),
    .lsu_fence_ack (lsu_fence_ack),
    .retire        (retire),
    .fence_stall   (fence_stall)
  );

  assign cur_state = state;

endmodule

/* tests/fence_unit_tb.sv */
// Fence unit testbench
// Directed tests of the CP0 fence sequencer, with request/done responders
// standing in for the LSU, D-cache, I-cache and MMU
`timescale 1ns/1ps

// Answers a request level with a one-cycle done pulse after a random delay
module done_responder (
  input  logic       fence_clk,
  input  logic [2:0] delay_cycles,
  input  logic       req_lvl,
  output logic       done
);

  int unsigned wait_cycles;

  initial
  begin
    done = 1'b0;
    forever
    begin
      @(negedge fence_clk);
      if (req_lvl)
      begin
        wait_cycles = delay_cycles;
        repeat (wait_cycles) @(negedge fence_clk);
        // Held for one full cycle so exactly one rising edge sees it
        done = 1'b1;
        @(negedge fence_clk);
        done = 1'b0;
      end
    end
  end

endmodule

module fence_unit_tb;

  localparam int unsigned timeout_cycles = 200;

  logic        fence_clk;
  logic        cpurst_b;
  logic        inst_issue;
  logic [31:0] inst_word;
  logic        dcacheop_req;
  logic        icacheop_req;
  logic        lsu_fence_ack;
  logic        lsu_sync_ack;
  logic        dcache_done;
  logic        icache_done;
  logic        mmu_done;

  fence_ctrl_pkg::fence_req_t    req;
  fence_ctrl_pkg::fence_retire_t retire;
  logic                          fence_stall;
  fence_ctrl_pkg::fence_state_e  cur_state;

  // Responder delay, redrawn on every rising edge
  logic [2:0] rsp_delay;
  // Distinct nonzero request levels in the order seen, and the order expected
  fence_ctrl_pkg::fence_req_t trail[$];
  fence_ctrl_pkg::fence_req_t exp_trail[$];

  fence_unit_top u_dut (
    .fence_clk     (fence_clk),
    .cpurst_b      (cpurst_b),
    .inst_issue    (inst_issue),
    .inst_word     (inst_word),
    .dcacheop_req  (dcacheop_req),
    .icacheop_req  (icacheop_req),
    .lsu_fence_ack (lsu_fence_ack),
    .lsu_sync_ack  (lsu_sync_ack),
    .dcache_done   (dcache_done),
    .icache_done   (icache_done),
    .mmu_done      (mmu_done),
    .req           (req),
    .retire        (retire),
    .fence_stall   (fence_stall),
    .cur_state     (cur_state)
  );

  // ==========================================================================
  // External responders
  // ==========================================================================
  done_responder u_lsu_fence_rsp (.fence_clk(fence_clk), .delay_cycles(rsp_delay),
                                  .req_lvl(req.lsu_fence), .done(lsu_fence_ack));
  done_responder u_lsu_sync_rsp  (.fence_clk(fence_clk), .delay_cycles(rsp_delay),
                                  .req_lvl(req.lsu_sync), .done(lsu_sync_ack));
  done_responder u_dcache_rsp    (.fence_clk(fence_clk), .delay_cycles(rsp_delay),
                                  .req_lvl(req.dcache), .done(dcache_done));
  done_responder u_icache_rsp    (.fence_clk(fence_clk), .delay_cycles(rsp_delay),
                                  .req_lvl(req.icache), .done(icache_done));
  done_responder u_mmu_rsp       (.fence_clk(fence_clk), .delay_cycles(rsp_delay),
                                  .req_lvl(req.mmu), .done(mmu_done));

  initial
  begin
    fence_clk = 1'b0;
    forever #10 fence_clk = ~fence_clk;
  end

  // Single random source, read by the responders on falling edges
  initial
  begin
    rsp_delay = $urandom(32'hb2c2) % 5;
    forever
    begin
      @(posedge fence_clk);
      rsp_delay = $urandom % 5;
    end
  end

  // ==========================================================================
  // Reporting and reference helpers
  // ==========================================================================
  task automatic end_with_failure;
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic timed_out(input string what);
    $display("TIMEOUT: %s never came within %0d cycles", what, timeout_cycles);
    end_with_failure();
  endtask

  // Request vector with one named level set
  function automatic fence_ctrl_pkg::fence_req_t req_only(input string name);
    fence_ctrl_pkg::fence_req_t r;
    r = '0;
    if (name == "lsu_fence")
      r.lsu_fence = 1'b1;
    else if (name == "lsu_sync")
      r.lsu_sync = 1'b1;
    else if (name == "dcache")
      r.dcache = 1'b1;
    else if (name == "icache")
      r.icache = 1'b1;
    else
      r.mmu = 1'b1;
    return r;
  endfunction

  // sfence.vma rs1, rs2 with rd = x0
  function automatic logic [31:0] sfence_word(input logic [4:0] rs1, input logic [4:0] rs2);
    return {7'b0001001, rs2, rs1, 3'b000, 5'd0, 7'b1110011};
  endfunction

  // Clear kind as {va_all, asid_all, va_asid}
  // None set flushes everything
  function automatic logic [2:0] expected_clr(input logic [4:0] rs1, input logic [4:0] rs2);
    if (rs1 != 0 && rs2 == 0)
      return 3'b100;
    else if (rs1 == 0 && rs2 != 0)
      return 3'b010;
    else if (rs1 != 0 && rs2 != 0)
      return 3'b001;
    return 3'b000;
  endfunction

  // ==========================================================================
  // Stimulus and monitors
  // ==========================================================================
  task automatic issue_word(input logic [31:0] word);
    @(negedge fence_clk);
    inst_issue = 1'b1;
    inst_word  = word;
    @(negedge fence_clk);
    inst_issue = 1'b0;
    inst_word  = 32'h0;
  endtask

  // Entered on a falling edge and returns in the sample of the retire pulse
  task automatic run_to_retire(input string what, input logic [2:0] exp_clr,
                               input logic stay_idle, input logic csr_mode,
                               input int inject_at, input logic [31:0] inject_word);
    fence_ctrl_pkg::fence_req_t last_req;
    fence_ctrl_pkg::fence_req_t done_q;
    logic [2:0] clr;
    int         cycles;
    logic       seen_done;
    last_req  = '0;
    done_q    = '0;
    cycles    = 0;
    seen_done = 1'b0;
    trail.delete();
    while (!seen_done)
    begin
      // CSR levels held until the completion cycle
      if (csr_mode && cur_state == fence_ctrl_pkg::fnc_cmplt)
      begin
        dcacheop_req = 1'b0;
        icacheop_req = 1'b0;
      end
      // Optional second strobe while busy
      if (inject_at > 0 && cycles == inject_at)
      begin
        inst_issue = 1'b1;
        inst_word  = inject_word;
      end
      else
      begin
        inst_issue = 1'b0;
        inst_word  = 32'h0;
      end
      // Settle past responder updates
      #2;
      check_val({what, " fence_stall"}, fence_stall, 1'b1);
      // A request answered last cycle must be gone now
      check_val({what, " req after done"}, req & done_q, '0);
      if (req != '0 && req != last_req)
        trail.push_back(req);
      last_req = req;
      clr = {retire.clr_va_all, retire.clr_asid_all, retire.clr_va_asid};
      check_val({what, " clear kind"}, clr, req.mmu ? exp_clr : 3'b000);
      if (stay_idle)
        check_val({what, " cur_state"}, cur_state, fence_ctrl_pkg::fnc_idle);
      done_q.lsu_fence = lsu_fence_ack;
      done_q.lsu_sync  = lsu_sync_ack;
      done_q.dcache    = dcache_done;
      done_q.icache    = icache_done;
      done_q.mmu       = mmu_done;
      seen_done = retire.done;
      // Plain fence retires in the cycle of its ack
      if (seen_done && stay_idle)
        check_val({what, " lsu_fence_ack at retire"}, lsu_fence_ack, 1'b1);
      if (!seen_done)
      begin
        cycles++;
        if (cycles > timeout_cycles)
          timed_out({what, " retire.done"});
        @(negedge fence_clk);
      end
    end
  endtask

  // Samples the current cycle first, then the following ones
  task automatic expect_quiet(input string what, input int n);
    repeat (n)
    begin
      #2;
      check_val({what, " fence_stall"}, fence_stall, 1'b0);
      check_val({what, " retire"}, retire, '0);
      check_val({what, " req"}, req, '0);
      check_val({what, " cur_state"}, cur_state, fence_ctrl_pkg::fnc_idle);
      @(negedge fence_clk);
    end
  endtask

  // Stall release, no second retire, request order
  task automatic finish_retire(input string what);
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge fence_clk);
      inst_issue = 1'b0;
      inst_word  = 32'h0;
      #2;
      check_val({what, " second retire.done"}, retire.done, 1'b0);
      cycles++;
      if (cycles > timeout_cycles)
        timed_out({what, " stall release"});
    end
    while (fence_stall);
    check_val({what, " request steps"}, trail.size(), exp_trail.size());
    for (int i = 0; i < exp_trail.size(); i++)
      check_val($sformatf("%s request step %0d", what, i), trail[i], exp_trail[i]);
    expect_quiet({what, " after retire"}, 4);
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================
  task automatic test_reset;
    check_val("reset req", req, '0);
    check_val("reset retire", retire, '0);
    check_val("reset fence_stall", fence_stall, 1'b0);
    check_val("reset cur_state", cur_state, fence_ctrl_pkg::fnc_idle);
  endtask

  task automatic test_fencei;
    exp_trail.delete();
    exp_trail.push_back(req_only("dcache"));
    exp_trail.push_back(req_only("icache"));
    issue_word(32'h0000100f);
    run_to_retire("fence.i", 3'b000, 1'b0, 1'b0, 0, 32'h0);
    finish_retire("fence.i");
  endtask

  task automatic test_sfence;
    logic [4:0] rs1;
    logic [4:0] rs2;
    string      what;
    for (int a = 0; a < 2; a++)
    begin
      for (int b = 0; b < 2; b++)
      begin
        rs1  = a ? 5'd5 : 5'd0;
        rs2  = b ? 5'd7 : 5'd0;
        what = $sformatf("sfence.vma x%0d x%0d", rs1, rs2);
        exp_trail.delete();
        exp_trail.push_back(req_only("mmu"));
        exp_trail.push_back(req_only("icache"));
        issue_word(sfence_word(rs1, rs2));
        run_to_retire(what, expected_clr(rs1, rs2), 1'b0, 1'b0, 0, 32'h0);
        finish_retire(what);
      end
    end
  endtask

  // sync, sync.i, then plain fence which stays in idle
  task automatic test_sync_fence;
    exp_trail.delete();
    exp_trail.push_back(req_only("lsu_sync"));
    issue_word(32'h0180000b);
    run_to_retire("sync", 3'b000, 1'b0, 1'b0, 0, 32'h0);
    finish_retire("sync");
    issue_word(32'h01a0000b);
    run_to_retire("sync.i", 3'b000, 1'b0, 1'b0, 0, 32'h0);
    finish_retire("sync.i");
    exp_trail.delete();
    exp_trail.push_back(req_only("lsu_fence"));
    issue_word(32'h0ff0000f);
    run_to_retire("fence", 3'b000, 1'b1, 1'b0, 0, 32'h0);
    finish_retire("fence");
  endtask

  task automatic test_csr_ops;
    exp_trail.delete();
    exp_trail.push_back(req_only("icache"));
    @(negedge fence_clk);
    icacheop_req = 1'b1;
    @(negedge fence_clk);
    run_to_retire("csr icacheop", 3'b000, 1'b0, 1'b1, 0, 32'h0);
    finish_retire("csr icacheop");
    exp_trail.delete();
    exp_trail.push_back(req_only("dcache"));
    @(negedge fence_clk);
    dcacheop_req = 1'b1;
    @(negedge fence_clk);
    run_to_retire("csr dcacheop", 3'b000, 1'b0, 1'b1, 0, 32'h0);
    finish_retire("csr dcacheop");
  endtask

  // sfence strobe during fence.i must leave no trace
  task automatic test_busy_and_nonspecial;
    exp_trail.delete();
    exp_trail.push_back(req_only("dcache"));
    exp_trail.push_back(req_only("icache"));
    issue_word(32'h0000100f);
    run_to_retire("busy fence.i", 3'b000, 1'b0, 1'b0, 1, sfence_word(5'd3, 5'd4));
    finish_retire("busy fence.i");
    // addi x0, x0, 0
    issue_word(32'h00000013);
    expect_quiet("non-special word", timeout_cycles);
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial
  begin
    cpurst_b     = 1'b0;
    inst_issue   = 1'b0;
    inst_word    = 32'h0;
    dcacheop_req = 1'b0;
    icacheop_req = 1'b0;
    repeat (3) @(negedge fence_clk);
    cpurst_b = 1'b1;
    #2;
    test_reset();
    test_fencei();
    test_sfence();
    test_sync_fence();
    test_csr_ops();
    test_busy_and_nonspecial();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* fence_unit_top.f */
hw/fence_inst_pkg.sv
hw/fence_ctrl_pkg.sv
hw/fence_special_decode.sv
hw/fence_seq_ctrl.sv
hw/fence_retire.sv
hw/fence_unit_top.sv
tests/fence_unit_tb.sv

/* Bender.yml */
package:
  name: fence_unit

dependencies: {}

sources:
  # Packages first, then the blocks, then the top level
  - files:
      - hw/fence_inst_pkg.sv
      - hw/fence_ctrl_pkg.sv
      - hw/fence_special_decode.sv
      - hw/fence_seq_ctrl.sv
      - hw/fence_retire.sv
      - hw/fence_unit_top.sv

  # Testbench, top module fence_unit_tb
  - target: test
    files:
      - tests/fence_unit_tb.sv
